/* axi_mem_consts.svh */
// Widths, depths, memory size and AXI encodings, included by every RTL and testbench file
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Bus field widths
`define AXI_MEM_ADDR_W 32
`define AXI_MEM_DATA_W 32
`define AXI_MEM_STRB_W 4
`define AXI_MEM_ID_W 4
`define AXI_MEM_LEN_W 8
`define AXI_MEM_SIZE_W 3
`define AXI_MEM_BURST_W 2
`define AXI_MEM_RESP_W 2

// Array geometry, one word per byte-lane group
`define AXI_MEM_BYTES 1024
`define AXI_MEM_WORDS 256
`define AXI_MEM_IDX_W 8

// Queue depths
`define AXI_MEM_CMD_DEPTH 4
`define AXI_MEM_B_DEPTH 4

// Burst types
`define AXI_BURST_FIXED 2'd0
`define AXI_BURST_INCR 2'd1
`define AXI_BURST_WRAP 2'd2

// Responses, numeric order matches severity
`define AXI_RESP_OKAY 2'd0
`define AXI_RESP_SLVERR 2'd2
`define AXI_RESP_DECERR 2'd3

`endif

/* axi_mem_pkg.sv */
// Memory word type shared by the array and both channels, referenced as axi_mem_pkg::mem_word_u
`default_nettype none

`include "axi_mem_consts.svh"

package axi_mem_pkg;

  // One array word, seen either as the bus data word or as its byte lanes
  typedef union packed {
    logic [`AXI_MEM_DATA_W-1:0]      word;
    logic [`AXI_MEM_STRB_W-1:0][7:0] bytes;
  } mem_word_u;

endpackage

`default_nettype wire

/* axi_cmd_fifo.sv */
// Synchronous circular FIFO for address commands and write responses, head shown combinationally
`timescale 1ns/100ps
`default_nettype none

module axi_cmd_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;
  logic             pop_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // Push when full and pop when empty are dropped
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push_ok && !pop_ok) count_q <= count_q + 1'b1;
      else if (pop_ok && !push_ok) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

/* axi_burst_ctrl.sv */
// Beat counter and address generator for the head command of one channel, with range checks
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_burst_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  start_addr_i,
  input  logic [`AXI_MEM_LEN_W-1:0]   len_i,
  input  logic [`AXI_MEM_SIZE_W-1:0]  size_i,
  input  logic [`AXI_MEM_BURST_W-1:0] burst_i,
  input  logic                        advance_i,
  output logic [`AXI_MEM_ADDR_W-1:0]  beat_addr_o,
  output logic [`AXI_MEM_LEN_W-1:0]   beat_cnt_o,
  output logic                        last_o,
  output logic [`AXI_MEM_RESP_W-1:0]  err_o
);

  logic [`AXI_MEM_LEN_W-1:0]  cnt_q;
  logic [`AXI_MEM_ADDR_W-1:0] addr_q;
  logic [`AXI_MEM_ADDR_W-1:0] beat_bytes;
  logic [`AXI_MEM_ADDR_W-1:0] next_addr;

  // First beat takes the command address directly
  assign beat_addr_o = (cnt_q == '0) ? start_addr_i : addr_q;
  assign beat_cnt_o  = cnt_q;
  assign last_o      = (cnt_q == len_i);

  // INCR steps from the aligned beat address
  assign beat_bytes = `AXI_MEM_ADDR_W'(1) << size_i;
  assign next_addr  = (beat_addr_o & ~(beat_bytes - 1'b1)) + beat_bytes;

  always_comb begin
    if (beat_addr_o >= `AXI_MEM_ADDR_W'(`AXI_MEM_BYTES)) begin
      err_o = `AXI_RESP_DECERR;
    end else if (burst_i == `AXI_BURST_WRAP) begin
      err_o = `AXI_RESP_SLVERR;
    end else begin
      err_o = `AXI_RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (advance_i) begin
      // Counter returns to zero so the next command starts at its own address
      if (last_o) cnt_q <= '0;
      else cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      addr_q <= (burst_i == `AXI_BURST_FIXED) ? start_addr_i : next_addr;
    end
  end

endmodule

`default_nettype wire

/* axi_mem_array.sv */
// Byte-strobed word array with one write port and a combinational read port
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_array (
  input  logic                         clk_i,
  input  logic                         we_i,
  input  logic [`AXI_MEM_IDX_W-1:0]    widx_i,
  input  logic [`AXI_MEM_STRB_W-1:0]   wstrb_i,
  input  axi_mem_pkg::mem_word_u       wdata_i,
  input  logic [`AXI_MEM_IDX_W-1:0]    ridx_i,
  output axi_mem_pkg::mem_word_u       rdata_o
);

  axi_mem_pkg::mem_word_u mem [`AXI_MEM_WORDS];

  // Contents start undefined and are loaded by writes only
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int lane = 0; lane < `AXI_MEM_STRB_W; lane++) begin
        if (wstrb_i[lane]) begin
          mem[widx_i].bytes[lane] <= wdata_i.bytes[lane];
        end
      end
    end
  end

  assign rdata_o = mem[ridx_i];

endmodule

`default_nettype wire

/* axi_write_chan.sv */
// AXI write path: AW queue, W beat acceptance into the array, B response queue and write monitor
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_write_chan (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i,
  input  logic [`AXI_MEM_LEN_W-1:0]   aw_len_i,
  input  logic [`AXI_MEM_SIZE_W-1:0]  aw_size_i,
  input  logic [`AXI_MEM_BURST_W-1:0] aw_burst_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`AXI_MEM_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    b_id_o,
  output logic [`AXI_MEM_RESP_W-1:0]  b_resp_o,
  output logic                        mem_we_o,
  output logic [`AXI_MEM_IDX_W-1:0]   mem_idx_o,
  output logic [`AXI_MEM_STRB_W-1:0]  mem_strb_o,
  output axi_mem_pkg::mem_word_u      mem_wdata_o,
  output logic                        mon_w_valid_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_w_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_w_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_w_id_o,
  output logic [`AXI_MEM_LEN_W-1:0]   mon_w_beat_count_o,
  output logic                        mon_w_last_o
);

  localparam int unsigned AW_W = `AXI_MEM_ID_W + `AXI_MEM_ADDR_W + `AXI_MEM_LEN_W
                               + `AXI_MEM_SIZE_W + `AXI_MEM_BURST_W;
  localparam int unsigned B_W  = `AXI_MEM_ID_W + `AXI_MEM_RESP_W;

  logic [AW_W-1:0]             aw_head;
  logic                        aw_empty;
  logic                        aw_full;
  logic [`AXI_MEM_ID_W-1:0]    cmd_id;
  logic [`AXI_MEM_ADDR_W-1:0]  cmd_addr;
  logic [`AXI_MEM_LEN_W-1:0]   cmd_len;
  logic [`AXI_MEM_SIZE_W-1:0]  cmd_size;
  logic [`AXI_MEM_BURST_W-1:0] cmd_burst;
  logic [B_W-1:0]              b_head;
  logic                        b_empty;
  logic                        b_full;
  logic                        w_hs;
  logic [`AXI_MEM_ADDR_W-1:0]  beat_addr;
  logic [`AXI_MEM_LEN_W-1:0]   beat_cnt;
  logic                        beat_last;
  logic [`AXI_MEM_RESP_W-1:0]  beat_err;
  logic [`AXI_MEM_RESP_W-1:0]  resp_q;
  logic [`AXI_MEM_RESP_W-1:0]  worst_resp;

  assign aw_ready_o = !aw_full;
  assign {cmd_id, cmd_addr, cmd_len, cmd_size, cmd_burst} = aw_head;

  axi_cmd_fifo #(.WIDTH(AW_W), .DEPTH(`AXI_MEM_CMD_DEPTH)) i_aw_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_valid_i && aw_ready_o),
    .data_i  ({aw_id_i, aw_addr_i, aw_len_i, aw_size_i, aw_burst_i}),
    .pop_i   (w_hs && beat_last),
    .data_o  (aw_head),
    .empty_o (aw_empty),
    .full_o  (aw_full)
  );

  axi_burst_ctrl i_burst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_addr_i (cmd_addr),
    .len_i        (cmd_len),
    .size_i       (cmd_size),
    .burst_i      (cmd_burst),
    .advance_i    (w_hs),
    .beat_addr_o  (beat_addr),
    .beat_cnt_o   (beat_cnt),
    .last_o       (beat_last),
    .err_o        (beat_err)
  );

  // Room for the response is reserved before any beat of the burst is taken
  assign w_ready_o = !aw_empty && !b_full;
  assign w_hs      = w_valid_i && w_ready_o;

  assign mem_we_o          = w_hs && (beat_err == `AXI_RESP_OKAY);
  assign mem_idx_o         = beat_addr[`AXI_MEM_IDX_W+1:2];
  assign mem_strb_o        = w_strb_i;
  assign mem_wdata_o.word  = w_data_i;

  // Encodings grow with severity, so the larger code wins
  assign worst_resp = (beat_err > resp_q) ? beat_err : resp_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_q <= `AXI_RESP_OKAY;
    end else if (w_hs) begin
      resp_q <= beat_last ? `AXI_RESP_OKAY : worst_resp;
    end
  end

  axi_cmd_fifo #(.WIDTH(B_W), .DEPTH(`AXI_MEM_B_DEPTH)) i_b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_hs && beat_last),
    .data_i  ({cmd_id, worst_resp}),
    .pop_i   (b_valid_o && b_ready_i),
    .data_o  (b_head),
    .empty_o (b_empty),
    .full_o  (b_full)
  );

  assign b_valid_o          = !b_empty;
  assign {b_id_o, b_resp_o} = b_head;

  // Write monitor, valid for the one cycle after each accepted beat
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) mon_w_valid_o <= 1'b0;
    else mon_w_valid_o <= w_hs;
  end

  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      mon_w_addr_o       <= beat_addr;
      mon_w_data_o       <= w_data_i;
      mon_w_id_o         <= cmd_id;
      mon_w_beat_count_o <= beat_cnt;
      mon_w_last_o       <= beat_last;
    end
  end

endmodule

`default_nettype wire

/* axi_read_chan.sv */
// AXI read path: AR queue, one R beat at a time from the array and the read monitor
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_read_chan (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  ar_addr_i,
  input  logic [`AXI_MEM_LEN_W-1:0]   ar_len_i,
  input  logic [`AXI_MEM_SIZE_W-1:0]  ar_size_i,
  input  logic [`AXI_MEM_BURST_W-1:0] ar_burst_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]  r_data_o,
  output logic [`AXI_MEM_RESP_W-1:0]  r_resp_o,
  output logic                        r_last_o,
  output logic [`AXI_MEM_IDX_W-1:0]   mem_idx_o,
  input  axi_mem_pkg::mem_word_u      mem_rdata_i,
  output logic                        mon_r_valid_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_r_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_r_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_r_id_o,
  output logic [`AXI_MEM_LEN_W-1:0]   mon_r_beat_count_o,
  output logic                        mon_r_last_o
);

  localparam int unsigned AR_W = `AXI_MEM_ID_W + `AXI_MEM_ADDR_W + `AXI_MEM_LEN_W
                               + `AXI_MEM_SIZE_W + `AXI_MEM_BURST_W;

  logic [AR_W-1:0]             ar_head;
  logic                        ar_empty;
  logic                        ar_full;
  logic [`AXI_MEM_ADDR_W-1:0]  cmd_addr;
  logic [`AXI_MEM_LEN_W-1:0]   cmd_len;
  logic [`AXI_MEM_SIZE_W-1:0]  cmd_size;
  logic [`AXI_MEM_BURST_W-1:0] cmd_burst;
  logic                        r_hs;
  logic [`AXI_MEM_ADDR_W-1:0]  beat_addr;
  logic [`AXI_MEM_LEN_W-1:0]   beat_cnt;

  assign ar_ready_o = !ar_full;
  assign {r_id_o, cmd_addr, cmd_len, cmd_size, cmd_burst} = ar_head;

  axi_cmd_fifo #(.WIDTH(AR_W), .DEPTH(`AXI_MEM_CMD_DEPTH)) i_ar_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (ar_valid_i && ar_ready_o),
    .data_i  ({ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i}),
    .pop_i   (r_hs && r_last_o),
    .data_o  (ar_head),
    .empty_o (ar_empty),
    .full_o  (ar_full)
  );

  axi_burst_ctrl i_burst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_addr_i (cmd_addr),
    .len_i        (cmd_len),
    .size_i       (cmd_size),
    .burst_i      (cmd_burst),
    .advance_i    (r_hs),
    .beat_addr_o  (beat_addr),
    .beat_cnt_o   (beat_cnt),
    .last_o       (r_last_o),
    .err_o        (r_resp_o)
  );

  // Beat stays on the bus until the master takes it
  assign r_valid_o = !ar_empty;
  assign r_hs      = r_valid_o && r_ready_i;
  assign mem_idx_o = beat_addr[`AXI_MEM_IDX_W+1:2];
  // Error beats return zero instead of array contents
  assign r_data_o  = (r_resp_o == `AXI_RESP_OKAY) ? mem_rdata_i.word : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) mon_r_valid_o <= 1'b0;
    else mon_r_valid_o <= r_hs;
  end

  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      mon_r_addr_o       <= beat_addr;
      mon_r_data_o       <= r_data_o;
      mon_r_id_o         <= r_id_o;
      mon_r_beat_count_o <= beat_cnt;
      mon_r_last_o       <= r_last_o;
    end
  end

endmodule

`default_nettype wire

/* axi_mem_top.sv */
// AXI4 slave memory top: joins the write channel, the read channel and the shared word array
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i,
  input  logic [`AXI_MEM_LEN_W-1:0]   aw_len_i,
  input  logic [`AXI_MEM_SIZE_W-1:0]  aw_size_i,
  input  logic [`AXI_MEM_BURST_W-1:0] aw_burst_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`AXI_MEM_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    b_id_o,
  output logic [`AXI_MEM_RESP_W-1:0]  b_resp_o,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`AXI_MEM_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_MEM_ADDR_W-1:0]  ar_addr_i,
  input  logic [`AXI_MEM_LEN_W-1:0]   ar_len_i,
  input  logic [`AXI_MEM_SIZE_W-1:0]  ar_size_i,
  input  logic [`AXI_MEM_BURST_W-1:0] ar_burst_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`AXI_MEM_ID_W-1:0]    r_id_o,
  output logic [`AXI_MEM_DATA_W-1:0]  r_data_o,
  output logic [`AXI_MEM_RESP_W-1:0]  r_resp_o,
  output logic                        r_last_o,
  output logic                        mon_w_valid_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_w_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_w_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_w_id_o,
  output logic [`AXI_MEM_LEN_W-1:0]   mon_w_beat_count_o,
  output logic                        mon_w_last_o,
  output logic                        mon_r_valid_o,
  output logic [`AXI_MEM_ADDR_W-1:0]  mon_r_addr_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mon_r_data_o,
  output logic [`AXI_MEM_ID_W-1:0]    mon_r_id_o,
  output logic [`AXI_MEM_LEN_W-1:0]   mon_r_beat_count_o,
  output logic                        mon_r_last_o
);

  logic                       mem_we;
  logic [`AXI_MEM_IDX_W-1:0]  mem_widx;
  logic [`AXI_MEM_STRB_W-1:0] mem_wstrb;
  axi_mem_pkg::mem_word_u     mem_wdata;
  logic [`AXI_MEM_IDX_W-1:0]  mem_ridx;
  axi_mem_pkg::mem_word_u     mem_rdata;

  // Bus and monitor ports share their names with the channel ports
  axi_write_chan i_write_chan (
    .mem_we_o    (mem_we),
    .mem_idx_o   (mem_widx),
    .mem_strb_o  (mem_wstrb),
    .mem_wdata_o (mem_wdata),
    .*
  );

  axi_read_chan i_read_chan (
    .mem_idx_o   (mem_ridx),
    .mem_rdata_i (mem_rdata),
    .*
  );

  axi_mem_array i_mem_array (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .widx_i  (mem_widx),
    .wstrb_i (mem_wstrb),
    .wdata_i (mem_wdata),
    .ridx_i  (mem_ridx),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

/* axi_mem_properties.sv */
// Protocol and timing properties of the AXI memory, bound to every axi_mem_top instance
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_properties (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       aw_ready_o,
  input logic                       ar_ready_o,
  input logic                       w_valid_i,
  input logic                       w_ready_o,
  input logic                       b_valid_o,
  input logic                       b_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]   b_id_o,
  input logic [`AXI_MEM_RESP_W-1:0] b_resp_o,
  input logic                       r_valid_o,
  input logic                       r_ready_i,
  input logic [`AXI_MEM_ID_W-1:0]   r_id_o,
  input logic [`AXI_MEM_DATA_W-1:0] r_data_o,
  input logic [`AXI_MEM_RESP_W-1:0] r_resp_o,
  input logic                       r_last_o,
  input logic                       mon_w_valid_o,
  input logic                       mon_r_valid_o
);

  // Failed property count, read by the testbench
  int prop_errors = 0;

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable({b_id_o, b_resp_o}))
  else begin
    prop_errors++;
    $error("B response changed while b_ready_i was low");
  end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_id_o, r_data_o, r_resp_o, r_last_o}))
  else begin
    prop_errors++;
    $error("R beat changed while r_ready_i was low");
  end

  // Monitor valid is the handshake delayed by one cycle
  mon_w_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mon_w_valid_o == $past(w_valid_i && w_ready_o))
  else begin
    prop_errors++;
    $error("Write monitor valid does not follow the W handshake by one cycle");
  end

  mon_r_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mon_r_valid_o == $past(r_valid_o && r_ready_i))
  else begin
    prop_errors++;
    $error("Read monitor valid does not follow the R handshake by one cycle");
  end

  reset_state: assert property (@(posedge clk_i) !rst_n_i |=>
    aw_ready_o && ar_ready_o && !w_ready_o && !b_valid_o && !r_valid_o
    && !mon_w_valid_o && !mon_r_valid_o)
  else begin
    prop_errors++;
    $error("Outputs not in their idle state after reset");
  end

endmodule

bind axi_mem_top axi_mem_properties i_axi_mem_properties (.*);

`default_nettype wire

/* axi_mem_tb.sv */
// Testbench for the AXI4 slave memory, top module axi_mem_tb, compiled with sim.f
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_consts.svh"

module axi_mem_tb;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int BEAT_BYTES      = 4;

  logic clk_i, rst_n_i, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  logic mon_w_valid_o, mon_w_last_o, mon_r_valid_o, mon_r_last_o;
  logic [`AXI_MEM_ID_W-1:0]    aw_id_i, b_id_o, ar_id_i, r_id_o, mon_w_id_o, mon_r_id_o;
  logic [`AXI_MEM_ADDR_W-1:0]  aw_addr_i, ar_addr_i, mon_w_addr_o, mon_r_addr_o;
  logic [`AXI_MEM_DATA_W-1:0]  w_data_i, r_data_o, mon_w_data_o, mon_r_data_o;
  logic [`AXI_MEM_LEN_W-1:0]   aw_len_i, ar_len_i, mon_w_beat_count_o, mon_r_beat_count_o;
  logic [`AXI_MEM_SIZE_W-1:0]  aw_size_i, ar_size_i;
  logic [`AXI_MEM_BURST_W-1:0] aw_burst_i, ar_burst_i;
  logic [`AXI_MEM_STRB_W-1:0]  w_strb_i;
  logic [`AXI_MEM_RESP_W-1:0]  b_resp_o, r_resp_o;

  // Byte-level reference memory and per-beat write data for the next burst
  logic [7:0]                  ref_mem [`AXI_MEM_BYTES];
  logic [`AXI_MEM_DATA_W-1:0]  wbuf [16];
  logic [`AXI_MEM_STRB_W-1:0]  sbuf [16];

  // Expected responses and beats in issue order
  logic [`AXI_MEM_ID_W-1:0]    exp_b_id [$], exp_r_id [$], exp_w_id [$];
  logic [`AXI_MEM_RESP_W-1:0]  exp_b_resp [$], exp_r_resp [$];
  logic [`AXI_MEM_ADDR_W-1:0]  exp_w_addr [$], exp_r_addr [$];
  logic [`AXI_MEM_DATA_W-1:0]  exp_w_data [$], exp_r_data [$];
  logic [`AXI_MEM_LEN_W-1:0]   exp_w_cnt [$], exp_r_cnt [$];
  logic                        exp_w_last [$], exp_r_last [$];

  // Values the monitors must show in the cycle after a handshake
  logic [`AXI_MEM_ADDR_W-1:0]  mw_addr, mr_addr;
  logic [`AXI_MEM_DATA_W-1:0]  mw_data, mr_data;
  logic [`AXI_MEM_ID_W-1:0]    mw_id, mr_id;
  logic [`AXI_MEM_LEN_W-1:0]   mw_cnt, mr_cnt;
  logic                        mw_last, mr_last;
  logic                        mw_pend = 1'b0;
  logic                        mr_pend = 1'b0;
  logic                        rand_ready = 1'b0;
  integer                      seed = 32'h3900;
  int                          errors = 0;
  int                          passed = 0;
  int                          mark = 0;
  int                          test_num = 0;

  axi_mem_top i_axi_mem_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic int total_errors();
    return errors + i_axi_mem_top.i_axi_mem_properties.prop_errors;
  endfunction

  function automatic logic [1:0] beat_resp(input logic [31:0] addr, input logic [1:0] burst);
    if (addr >= `AXI_MEM_BYTES) return `AXI_RESP_DECERR;
    if (burst == `AXI_BURST_WRAP) return `AXI_RESP_SLVERR;
    return `AXI_RESP_OKAY;
  endfunction

  // FIXED repeats the start address, otherwise step to the next aligned beat
  function automatic logic [31:0] next_beat(input logic [31:0] addr, input logic [31:0] start,
                                            input logic [1:0] burst);
    if (burst == `AXI_BURST_FIXED) return start;
    return (addr / BEAT_BYTES) * BEAT_BYTES + BEAT_BYTES;
  endfunction

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                             input logic [1:0] burst);
    logic [31:0] a;
    logic        decerr;
    a      = addr;
    decerr = 1'b0;
    for (int i = 0; i <= len; i++) begin
      exp_w_addr.push_back(a);
      exp_w_data.push_back(wbuf[i]);
      exp_w_id.push_back(id);
      exp_w_cnt.push_back(`AXI_MEM_LEN_W'(i));
      exp_w_last.push_back(i == len);
      if (beat_resp(a, burst) == `AXI_RESP_DECERR) decerr = 1'b1;
      if (beat_resp(a, burst) == `AXI_RESP_OKAY) begin
        for (int lane = 0; lane < BEAT_BYTES; lane++) begin
          if (sbuf[i][lane]) ref_mem[(a & ~32'h3) + lane] = wbuf[i][8*lane +: 8];
        end
      end
      a = next_beat(a, addr, burst);
    end
    exp_b_id.push_back(id);
    exp_b_resp.push_back(decerr ? `AXI_RESP_DECERR : beat_resp(addr, burst));
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_id_i    <= id;
    aw_addr_i  <= addr;
    aw_len_i   <= `AXI_MEM_LEN_W'(len);
    aw_size_i  <= 3'd2;
    aw_burst_i <= burst;
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    aw_valid_i <= 1'b0;
    for (int i = 0; i <= len; i++) begin
      w_valid_i <= 1'b1;
      w_data_i  <= wbuf[i];
      w_strb_i  <= sbuf[i];
      @(posedge clk_i);
      while (!w_ready_o) @(posedge clk_i);
    end
    w_valid_i <= 1'b0;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                            input logic [1:0] burst);
    logic [31:0] a;
    logic [31:0] d;
    a = addr;
    for (int i = 0; i <= len; i++) begin
      d = '0;
      if (beat_resp(a, burst) == `AXI_RESP_OKAY) begin
        for (int lane = 0; lane < BEAT_BYTES; lane++) d[8*lane +: 8] = ref_mem[(a & ~32'h3) + lane];
      end
      exp_r_id.push_back(id);
      exp_r_resp.push_back(beat_resp(a, burst));
      exp_r_data.push_back(d);
      exp_r_addr.push_back(a);
      exp_r_cnt.push_back(`AXI_MEM_LEN_W'(i));
      exp_r_last.push_back(i == len);
      a = next_beat(a, addr, burst);
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_id_i    <= id;
    ar_addr_i  <= addr;
    ar_len_i   <= `AXI_MEM_LEN_W'(len);
    ar_size_i  <= 3'd2;
    ar_burst_i <= burst;
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    ar_valid_i <= 1'b0;
  endtask

  // Done once every expected beat and response has been seen, monitors included
  task automatic wait_idle();
    while (exp_b_id.size() != 0 || exp_r_id.size() != 0 || exp_w_addr.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic finish_test(input string name);
    int now_errors;
    wait_idle();
    now_errors = total_errors();
    test_num++;
    if (now_errors == mark) passed++;
    $display("Test %0d %s: %s", test_num, name, (now_errors == mark) ? "passed" : "failed");
    mark = now_errors;
  endtask

  // Ready driver, response checks and monitor follow-up, sampled at the rising edge
  always @(posedge clk_i) begin
    b_ready_i <= !rand_ready || ($random(seed) & 1);
    r_ready_i <= !rand_ready || ($random(seed) & 1);
    if (mw_pend) begin
      check_val("mon_w_addr_o", mon_w_addr_o, mw_addr);
      check_val("mon_w_data_o", mon_w_data_o, mw_data);
      check_val("mon_w_id_o", mon_w_id_o, mw_id);
      check_val("mon_w_beat_count_o", mon_w_beat_count_o, mw_cnt);
      check_val("mon_w_last_o", mon_w_last_o, mw_last);
    end
    if (mr_pend) begin
      check_val("mon_r_addr_o", mon_r_addr_o, mr_addr);
      check_val("mon_r_data_o", mon_r_data_o, mr_data);
      check_val("mon_r_id_o", mon_r_id_o, mr_id);
      check_val("mon_r_beat_count_o", mon_r_beat_count_o, mr_cnt);
      check_val("mon_r_last_o", mon_r_last_o, mr_last);
    end
    mw_pend = rst_n_i && w_valid_i && w_ready_o;
    mr_pend = 1'b0;
    if (mw_pend) begin
      mw_addr = exp_w_addr.pop_front();
      mw_data = exp_w_data.pop_front();
      mw_id   = exp_w_id.pop_front();
      mw_cnt  = exp_w_cnt.pop_front();
      mw_last = exp_w_last.pop_front();
    end
    if (rst_n_i && r_valid_o && r_ready_i) begin
      if (exp_r_id.size() == 0) begin
        $display("R beat returned while no read was outstanding");
        errors++;
      end else begin
        mr_pend = 1'b1;
        mr_addr = exp_r_addr.pop_front();
        mr_data = exp_r_data.pop_front();
        mr_id   = exp_r_id.pop_front();
        mr_cnt  = exp_r_cnt.pop_front();
        mr_last = exp_r_last.pop_front();
        check_val("r_id_o", r_id_o, mr_id);
        check_val("r_resp_o", r_resp_o, exp_r_resp.pop_front());
        check_val("r_data_o", r_data_o, mr_data);
        check_val("r_last_o", r_last_o, mr_last);
      end
    end
    if (rst_n_i && b_valid_o && b_ready_i) begin
      if (exp_b_id.size() == 0) begin
        $display("B response returned while no write was outstanding");
        errors++;
      end else begin
        check_val("b_id_o", b_id_o, exp_b_id.pop_front());
        check_val("b_resp_o", b_resp_o, exp_b_resp.pop_front());
      end
    end
  end

  initial begin
    rst_n_i   = 1'b0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    {aw_valid_i, aw_id_i, aw_addr_i, aw_len_i, aw_size_i, aw_burst_i} = '0;
    {w_valid_i, w_data_i, w_strb_i} = '0;
    {ar_valid_i, ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i} = '0;
    for (int i = 0; i < 16; i++) sbuf[i] = 4'hF;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    wbuf[0] = 32'hCAFE_F00D;
    write_burst(4'h3, 32'h010, 0, `AXI_BURST_INCR);
    wait_idle();
    read_burst(4'h5, 32'h010, 0, `AXI_BURST_INCR);
    finish_test("single beat");

    for (int i = 0; i < 4; i++) wbuf[i] = 32'h1000_0000 + i * 32'h0101_0101;
    write_burst(4'h1, 32'h100, 3, `AXI_BURST_INCR);
    wait_idle();
    read_burst(4'h2, 32'h100, 3, `AXI_BURST_INCR);
    finish_test("incr burst");

    wbuf[0] = 32'hAABB_CCDD;
    write_burst(4'h4, 32'h040, 0, `AXI_BURST_INCR);
    wbuf[0] = 32'h1122_3344;
    sbuf[0] = 4'b0101;
    write_burst(4'h6, 32'h040, 0, `AXI_BURST_INCR);
    sbuf[0] = 4'hF;
    wait_idle();
    read_burst(4'h7, 32'h040, 0, `AXI_BURST_INCR);
    finish_test("strobe merge");

    for (int i = 0; i < 3; i++) wbuf[i] = 32'h5A00_0000 + i;
    write_burst(4'h8, 32'h080, 2, `AXI_BURST_FIXED);
    wait_idle();
    read_burst(4'h9, 32'h080, 0, `AXI_BURST_INCR);
    finish_test("fixed burst");

    // Crossing the end of the array, then a WRAP over the incr burst data
    for (int i = 0; i < 4; i++) wbuf[i] = 32'hD000_0000 + i;
    write_burst(4'hA, 32'h3F8, 3, `AXI_BURST_INCR);
    write_burst(4'hB, 32'h100, 1, `AXI_BURST_WRAP);
    wait_idle();
    read_burst(4'hC, 32'h3F8, 3, `AXI_BURST_INCR);
    read_burst(4'hD, 32'h100, 1, `AXI_BURST_WRAP);
    read_burst(4'hE, 32'h100, 1, `AXI_BURST_INCR);
    finish_test("error bursts");

    rand_ready = 1'b1;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk_i);
      for (int i = 0; i < 4; i++) wbuf[i] = $random(seed);
      write_burst(4'(k), 32'h200 + 16 * k, 3, `AXI_BURST_INCR);
    end
    wait_idle();
    for (int k = 0; k < 4; k++) read_burst(4'(8 + k), 32'h200 + 16 * k, 3, `AXI_BURST_INCR);
    finish_test("back-pressure");
    rand_ready = 1'b0;

    $display("Summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the number of tests
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
axi_mem_pkg.sv
axi_cmd_fifo.sv
axi_burst_ctrl.sv
axi_mem_array.sv
axi_write_chan.sv
axi_read_chan.sv
axi_mem_top.sv
axi_mem_properties.sv
axi_mem_tb.sv
